//--- logic/sdramPkg.sv
`default_nettype none

package sdramPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int dataWidth = 32;	// Column word
	localparam int byteOffBits = 2;	// Byte select within a word

	// Row array comes out of reset as all ones in every word, the row
	// buffer as zero. Only the bank applies this rule.

	//////////////////////////////////////////////////////////////////////
	// Command opcodes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		opActivate = 2'd0,
		opPrecharge = 2'd1,
		opRead = 2'd2,
		opWrite = 2'd3
	} opE;

	//////////////////////////////////////////////////////////////////////
	// Access sizes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0]
	{
		sizeByte = 2'b00,
		sizeHalf = 2'b01,
		sizeWord = 2'b10	// 2'b11 also taken as a word
	} sizeE;

endpackage

`default_nettype wire

//--- logic/sdramCmdDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module sdramCmdDecoder #(
	parameter int numBanks = 4,
	parameter int rowBits = 4,
	parameter int colBits = 5
) (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	output logic cmdReady,
	input sdramPkg::opE cmdOp,
	input logic [$clog2(numBanks)-1:0] cmdBank,
	input logic [rowBits-1:0] cmdRow,
	input logic [colBits-1:0] cmdCol,
	input sdramPkg::sizeE cmdSize,
	input logic [sdramPkg::dataWidth-1:0] cmdData,
	output logic cmdError,
	output logic [numBanks-1:0] bankValid,
	input logic [numBanks-1:0] bankReady,
	output sdramPkg::opE bankOp,
	output logic [rowBits-1:0] bankRow,
	output logic [colBits-1:0] bankCol,
	output sdramPkg::sizeE bankSize,
	output logic [sdramPkg::dataWidth-1:0] bankData
);

	import sdramPkg::*;

	localparam int bankBits = $clog2(numBanks);

	logic initDone;
	logic regValid;
	opE regOp;
	logic [bankBits-1:0] regBank;
	logic [rowBits-1:0] regRow;
	logic [colBits-1:0] regCol;
	sizeE regSize;
	logic [dataWidth-1:0] regData;

	logic [numBanks-1:0] bankOpen;
	logic legal;
	logic fwd;
	logic regLeave;
	logic load;

	// Activate wants a closed bank, everything else an open one
	assign legal = (regOp == opActivate) ? !bankOpen[regBank] : bankOpen[regBank];

	assign fwd = regValid && legal && bankReady[regBank];
	assign regLeave = fwd || (regValid && !legal);	// Illegal ones are dropped
	assign cmdReady = initDone && (!regValid || regLeave);
	assign load = cmdValid && cmdReady;
	assign cmdError = regValid && !legal;

	always_comb
	begin
		bankValid = '0;
		bankValid[regBank] = regValid && legal;
	end

	assign bankOp = regOp;
	assign bankRow = regRow;
	assign bankCol = regCol;
	assign bankSize = regSize;
	assign bankData = regData;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			initDone <= 1'b0;
			regValid <= 1'b0;
			bankOpen <= '0;
		end
		else
		begin
			initDone <= 1'b1;
			if (load)
				regValid <= 1'b1;
			else if (regLeave)
				regValid <= 1'b0;
			if (fwd && regOp == opActivate)
				bankOpen[regBank] <= 1'b1;
			else if (fwd && regOp == opPrecharge)
				bankOpen[regBank] <= 1'b0;
		end
	end

	// Command payload
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			regOp <= cmdOp;
			regBank <= cmdBank;
			regRow <= cmdRow;
			regCol <= cmdCol;
			regSize <= cmdSize;
			regData <= cmdData;
		end
	end

endmodule

`default_nettype wire

//--- logic/sdramBank.sv
`timescale 1ns/1ps
`default_nettype none

module sdramBank #(
	parameter int rowBits = 4,
	parameter int colBits = 5
) (
	input logic clk,
	input logic rstN,
	input logic bankValid,
	output logic bankReady,
	input sdramPkg::opE bankOp,
	input logic [rowBits-1:0] bankRow,
	input logic [colBits-1:0] bankCol,
	input sdramPkg::sizeE bankSize,
	input logic [sdramPkg::dataWidth-1:0] bankData,
	output logic respValid,
	input logic respReady,
	output logic [sdramPkg::dataWidth-1:0] respWord,
	output sdramPkg::sizeE respSize,
	output logic [sdramPkg::byteOffBits-1:0] respByteOff
);

	import sdramPkg::*;

	localparam int wordBits = colBits - byteOffBits;
	localparam int numWords = 1 << wordBits;
	localparam int numRows = 1 << rowBits;

	logic [dataWidth-1:0] rowMem [numRows][numWords];
	logic [dataWidth-1:0] rowBuf [numWords];

	logic awake;
	logic busy;		// Copy in progress
	logic loading;	// Row to buffer when set, buffer to row otherwise
	logic [wordBits-1:0] wordCnt;
	logic [rowBits-1:0] openRow;

	logic accept;
	logic [wordBits-1:0] colWord;
	logic [byteOffBits-1:0] byteOff;
	logic [dataWidth-1:0] wrWord;

	assign colWord = bankCol[colBits-1:byteOffBits];
	assign byteOff = bankCol[byteOffBits-1:0];

	// A pending response blocks new commands unless it leaves this cycle
	assign bankReady = awake && !busy && (!respValid || respReady);
	assign accept = bankValid && bankReady;

	//////////////////////////////////////////////////////////////////////
	// Byte-lane write merge
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		wrWord = rowBuf[colWord];
		case (bankSize)
			sizeByte:
			begin
				wrWord[8*byteOff +: 8] = bankData[7:0];
			end
			sizeHalf:
			begin
				wrWord[16*byteOff[1] +: 16] = bankData[15:0];	// Bit 0 ignored
			end
			default:
			begin
				wrWord = bankData;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Copy sequencer, buffer writes and read launch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			awake <= 1'b0;
			busy <= 1'b0;
			loading <= 1'b0;
			wordCnt <= '0;
			openRow <= '0;
			respValid <= 1'b0;
			for (int r = 0; r < numRows; r++)
			begin
				for (int w = 0; w < numWords; w++)
				begin
					rowMem[r][w] <= '1;
				end
			end
			for (int w = 0; w < numWords; w++)
			begin
				rowBuf[w] <= '0;
			end
		end
		else
		begin
			awake <= 1'b1;
			if (respValid && respReady)
				respValid <= 1'b0;

			if (busy)
			begin
				// One word per cycle
				if (loading)
					rowBuf[wordCnt] <= rowMem[openRow][wordCnt];
				else
					rowMem[openRow][wordCnt] <= rowBuf[wordCnt];
				wordCnt <= wordCnt + 1'b1;	// Wraps back to zero at the end
				if (wordCnt == wordBits'(numWords - 1))
					busy <= 1'b0;
			end
			else if (accept)
			begin
				case (bankOp)
					opActivate:
					begin
						openRow <= bankRow;
						busy <= 1'b1;
						loading <= 1'b1;
					end
					opPrecharge:
					begin
						busy <= 1'b1;
						loading <= 1'b0;	// Back to the latched row
					end
					opRead:
					begin
						respValid <= 1'b1;
					end
					default:
					begin
						rowBuf[colWord] <= wrWord;
					end
				endcase
			end
		end
	end

	// Response payload
	always_ff @(posedge clk)
	begin
		if (accept && bankOp == opRead)
		begin
			respWord <= rowBuf[colWord];
			respSize <= bankSize;
			respByteOff <= byteOff;
		end
	end

endmodule

`default_nettype wire

//--- logic/sdramReadReturn.sv
`timescale 1ns/1ps
`default_nettype none

module sdramReadReturn #(
	parameter int numBanks = 4
) (
	input logic clk,
	input logic rstN,
	input logic [numBanks-1:0] respValid,
	output logic [numBanks-1:0] respReady,
	input logic [sdramPkg::dataWidth-1:0] respWord [numBanks],
	input sdramPkg::sizeE respSize [numBanks],
	input logic [sdramPkg::byteOffBits-1:0] respByteOff [numBanks],
	output logic rdValid,
	input logic rdReady,
	output logic [sdramPkg::dataWidth-1:0] rdData,
	output logic [$clog2(numBanks)-1:0] rdBank
);

	import sdramPkg::*;

	localparam int bankBits = $clog2(numBanks);

	logic [bankBits-1:0] lastGrant;
	logic [bankBits-1:0] grantIdx;
	logic found;
	logic take;
	logic [dataWidth-1:0] selWord;
	logic [byteOffBits-1:0] selOff;
	logic [dataWidth-1:0] extData;

	//////////////////////////////////////////////////////////////////////
	// Round-robin pick, starting after the last grant
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		int idx;
		found = 1'b0;
		grantIdx = lastGrant;
		for (int off = 1; off <= numBanks; off++)
		begin
			idx = (int'(lastGrant) + off) % numBanks;
			if (!found && respValid[idx])
			begin
				found = 1'b1;
				grantIdx = bankBits'(idx);
			end
		end
	end

	assign take = found && (!rdValid || rdReady);	// Output empty or draining

	always_comb
	begin
		respReady = '0;
		respReady[grantIdx] = take;
	end

	// Lane extraction, zero-extended
	assign selWord = respWord[grantIdx];
	assign selOff = respByteOff[grantIdx];

	always_comb
	begin
		extData = '0;
		case (respSize[grantIdx])
			sizeByte: extData[7:0] = selWord[8*selOff +: 8];
			sizeHalf: extData[15:0] = selWord[16*selOff[1] +: 16];
			default: extData = selWord;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rdValid <= 1'b0;
			lastGrant <= bankBits'(numBanks - 1);	// Bank 0 wins first
		end
		else if (take)
		begin
			rdValid <= 1'b1;
			lastGrant <= grantIdx;
		end
		else if (rdReady)
			rdValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			rdData <= extData;
			rdBank <= grantIdx;
		end
	end

endmodule

`default_nettype wire

//--- logic/sdramCore.sv
`timescale 1ns/1ps
`default_nettype none

module sdramCore #(
	parameter int numBanks = 4,
	parameter int rowBits = 4,
	parameter int colBits = 5
) (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	output logic cmdReady,
	input sdramPkg::opE cmdOp,
	input logic [$clog2(numBanks)-1:0] cmdBank,
	input logic [rowBits-1:0] cmdRow,
	input logic [colBits-1:0] cmdCol,
	input sdramPkg::sizeE cmdSize,
	input logic [sdramPkg::dataWidth-1:0] cmdData,
	output logic rdValid,
	input logic rdReady,
	output logic [sdramPkg::dataWidth-1:0] rdData,
	output logic [$clog2(numBanks)-1:0] rdBank,
	output logic cmdError
);

	import sdramPkg::*;

	// Decoder to banks, all but valid/ready shared
	logic [numBanks-1:0] bankValid;
	logic [numBanks-1:0] bankReady;
	opE bankOp;
	logic [rowBits-1:0] bankRow;
	logic [colBits-1:0] bankCol;
	sizeE bankSize;
	logic [dataWidth-1:0] bankData;

	// Banks to read return
	logic [numBanks-1:0] respValid;
	logic [numBanks-1:0] respReady;
	logic [dataWidth-1:0] respWord [numBanks];
	sizeE respSize [numBanks];
	logic [byteOffBits-1:0] respByteOff [numBanks];

	//////////////////////////////////////////////////////////////////////
	// Command decoder
	//////////////////////////////////////////////////////////////////////

	sdramCmdDecoder #(
		.numBanks(numBanks),
		.rowBits(rowBits),
		.colBits(colBits)
	) u_decoder (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmdOp(cmdOp),
		.cmdBank(cmdBank),
		.cmdRow(cmdRow),
		.cmdCol(cmdCol),
		.cmdSize(cmdSize),
		.cmdData(cmdData),
		.cmdError(cmdError),
		.bankValid(bankValid),
		.bankReady(bankReady),
		.bankOp(bankOp),
		.bankRow(bankRow),
		.bankCol(bankCol),
		.bankSize(bankSize),
		.bankData(bankData)
	);

	//////////////////////////////////////////////////////////////////////
	// Banks
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < numBanks; i++)
	begin : gBank
		sdramBank #(
			.rowBits(rowBits),
			.colBits(colBits)
		) u_bank (
			.clk(clk),
			.rstN(rstN),
			.bankValid(bankValid[i]),
			.bankReady(bankReady[i]),
			.bankOp(bankOp),
			.bankRow(bankRow),
			.bankCol(bankCol),
			.bankSize(bankSize),
			.bankData(bankData),
			.respValid(respValid[i]),
			.respReady(respReady[i]),
			.respWord(respWord[i]),
			.respSize(respSize[i]),
			.respByteOff(respByteOff[i])
		);
	end

	// Read responses to the output port
	sdramReadReturn #(
		.numBanks(numBanks)
	) u_readReturn (
		.clk(clk),
		.rstN(rstN),
		.respValid(respValid),
		.respReady(respReady),
		.respWord(respWord),
		.respSize(respSize),
		.respByteOff(respByteOff),
		.rdValid(rdValid),
		.rdReady(rdReady),
		.rdData(rdData),
		.rdBank(rdBank)
	);

endmodule

`default_nettype wire

//--- dv/sdramCoreTable.svh
// Directed command table
// Columns are op, bank, row, byte column, size, data, expected error and rdReady low cycles

task automatic addEntry(input opE op, input int bank, input int row, input int col,
	input sizeE size, input logic [dataWidth-1:0] data, input logic err, input int hold);
	tblOp.push_back(op);
	tblBank.push_back(bank);
	tblRow.push_back(row);
	tblCol.push_back(col);
	tblSize.push_back(size);
	tblData.push_back(data);
	tblErr.push_back(err);
	tblHold.push_back(hold);
endtask

task automatic loadTable();
	// Fresh row reads as all ones
	addEntry(opActivate,  0, 3,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  5, sizeByte, 32'h0000_0000, 1'b0, 0);

	// Odd half offset lands on the upper half
	addEntry(opWrite,     0, 0,  4, sizeWord, 32'h1234_5678, 1'b0, 0);
	addEntry(opWrite,     0, 0,  5, sizeByte, 32'hFFFF_FFAB, 1'b0, 0);
	addEntry(opWrite,     0, 0,  7, sizeHalf, 32'h9999_CDEF, 1'b0, 0);
	addEntry(opRead,      0, 0,  4, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  6, sizeByte, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  7, sizeHalf, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  5, sizeHalf, 32'h0000_0000, 1'b0, 0);
	addEntry(opWrite,     0, 0,  1, sizeHalf, 32'h0000_5566, 1'b0, 0);
	addEntry(opRead,      0, 0,  0, sizeWord, 32'h0000_0000, 1'b0, 0);

	// Write-back and reopen
	addEntry(opPrecharge, 0, 0,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opActivate,  0, 3,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  4, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opPrecharge, 0, 0,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opActivate,  0, 9,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  4, sizeWord, 32'h0000_0000, 1'b0, 0);

	// Illegal commands
	addEntry(opRead,      1, 0,  0, sizeWord, 32'h0000_0000, 1'b1, 0);
	addEntry(opActivate,  0, 3,  0, sizeWord, 32'h0000_0000, 1'b1, 0);
	addEntry(opPrecharge, 2, 0,  0, sizeWord, 32'h0000_0000, 1'b1, 0);
	addEntry(opRead,      0, 0,  4, sizeWord, 32'h0000_0000, 1'b0, 0);

	// Back-pressure with reads spread over banks
	addEntry(opActivate,  1, 2,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opActivate,  2, 0,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opActivate,  3, 7,  0, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opWrite,     1, 0,  8, sizeWord, 32'h1111_2211, 1'b0, 0);
	addEntry(opWrite,     2, 0,  8, sizeWord, 32'h2222_3322, 1'b0, 0);
	addEntry(opRead,      1, 0,  8, sizeWord, 32'h0000_0000, 1'b0, 12);
	addEntry(opRead,      2, 0,  8, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      3, 0,  8, sizeWord, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      1, 0,  9, sizeByte, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      2, 0, 14, sizeHalf, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      0, 0,  4, sizeByte, 32'h0000_0000, 1'b0, 0);
	addEntry(opRead,      1, 0,  8, sizeWord, 32'h0000_0000, 1'b0, 6);
	addEntry(opRead,      3, 0, 31, sizeByte, 32'h0000_0000, 1'b0, 0);
endtask

//--- dv/sdramCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module sdramCoreTb;

	import sdramPkg::*;

	localparam int numBanks = 4;
	localparam int rowBits = 4;
	localparam int colBits = 5;
	localparam int bankBits = $clog2(numBanks);
	localparam int numRows = 1 << rowBits;
	localparam int numWords = 1 << (colBits - byteOffBits);
	localparam int numRandom = 200;

	logic clk;
	logic rstN;
	logic cmdValid;
	logic cmdReady;
	opE cmdOp;
	logic [bankBits-1:0] cmdBank;
	logic [rowBits-1:0] cmdRow;
	logic [colBits-1:0] cmdCol;
	sizeE cmdSize;
	logic [dataWidth-1:0] cmdData;
	logic rdValid;
	logic rdReady;
	logic [dataWidth-1:0] rdData;
	logic [bankBits-1:0] rdBank;
	logic cmdError;

	// Table columns
	opE tblOp [$];
	int tblBank [$];
	int tblRow [$];
	int tblCol [$];
	sizeE tblSize [$];
	logic [dataWidth-1:0] tblData [$];
	logic tblErr [$];
	int tblHold [$];

	// Reference model
	logic [dataWidth-1:0] modelMem [numBanks*numRows*numWords];
	logic [dataWidth-1:0] modelBuf [numBanks*numWords];
	logic modelOpen [numBanks];
	int modelRow [numBanks];
	int expBankQ [$];
	logic [dataWidth-1:0] expDataQ [$];

	int errors;
	int cycles;
	int limit = 0;
	int holdLeft;
	logic randPhase;
	logic curErr;	// Expected error of the command being driven
	logic errExp;
	logic holdValid;
	logic [dataWidth-1:0] holdData;
	logic [bankBits-1:0] holdBank;
	logic [31:0] rngState;

	`include "sdramCoreTable.svh"

	sdramCore #(
		.numBanks(numBanks),
		.rowBits(rowBits),
		.colBits(colBits)
	) u_dut (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmdOp(cmdOp),
		.cmdBank(cmdBank),
		.cmdRow(cmdRow),
		.cmdCol(cmdCol),
		.cmdSize(cmdSize),
		.cmdData(cmdData),
		.rdValid(rdValid),
		.rdReady(rdReady),
		.rdData(rdData),
		.rdBank(rdBank),
		.cmdError(cmdError)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Lane rules
	////////////////////////////////////////////////////////////////////

	function automatic int laneShift(sizeE size, logic [1:0] off);
		case (size)
			sizeByte: return 8 * off;
			sizeHalf: return off[1] ? 16 : 0;	// Odd byte ignored
			default: return 0;
		endcase
	endfunction

	function automatic logic [31:0] laneMask(sizeE size, logic [1:0] off);
		case (size)
			sizeByte: return 32'h0000_00FF << laneShift(size, off);
			sizeHalf: return 32'h0000_FFFF << laneShift(size, off);
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	// Model update at each command transfer
	task automatic applyCmd();
		logic illegal;
		logic [31:0] mask;
		int shift;
		int b;
		int w;
		int base;
		b = cmdBank;
		illegal = (cmdOp == opActivate) ? modelOpen[b] : !modelOpen[b];
		assert (illegal == curErr)
		else
		begin
			errors++;
			$display("Legality of %s to bank %0d at %0t is not what the test expects",
				cmdOp.name(), b, $time);
		end
		errExp = illegal;
		mask = laneMask(cmdSize, cmdCol[1:0]);
		shift = laneShift(cmdSize, cmdCol[1:0]);
		w = b * numWords + cmdCol[colBits-1:byteOffBits];
		if (!illegal)
		begin
			case (cmdOp)
				opActivate:
				begin
					modelOpen[b] = 1'b1;
					modelRow[b] = cmdRow;
					base = (b * numRows + cmdRow) * numWords;
					for (int i = 0; i < numWords; i++)
						modelBuf[b*numWords + i] = modelMem[base + i];
				end
				opPrecharge:
				begin
					modelOpen[b] = 1'b0;
					base = (b * numRows + modelRow[b]) * numWords;
					for (int i = 0; i < numWords; i++)
						modelMem[base + i] = modelBuf[b*numWords + i];
				end
				opWrite:
					modelBuf[w] = (modelBuf[w] & ~mask) | ((cmdData << shift) & mask);
				default:
				begin
					expBankQ.push_back(b);
					expDataQ.push_back((modelBuf[w] & mask) >> shift);
				end
			endcase
		end
	endtask

	task automatic checkRead();
		int idx;
		idx = -1;
		for (int i = expBankQ.size() - 1; i >= 0; i--)
			if (expBankQ[i] == rdBank)
				idx = i;	// Oldest one of this bank
		assert (idx >= 0)
		else
		begin
			errors++;
			$display("Read data from bank %0d at %0t with no read outstanding", rdBank, $time);
		end
		if (idx >= 0)
		begin
			assert (rdData == expDataQ[idx])
			else
			begin
				errors++;
				$display("MISMATCH at %0t: rdData expected %h, got %h",
					$time, expDataQ[idx], rdData);
			end
			expBankQ.delete(idx);
			expDataQ.delete(idx);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Monitor, mid-cycle
	////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (rstN)
		begin
			cycles++;
			assert (cmdError == errExp)
			else
			begin
				errors++;
				$display("MISMATCH at %0t: cmdError expected %0b, got %0b",
					$time, errExp, cmdError);
			end
			errExp = 1'b0;
			if (cmdValid && cmdReady)
				applyCmd();
			if (holdValid)
			begin
				assert (rdValid)
				else
				begin
					errors++;
					$display("rdValid dropped at %0t before rdReady was high", $time);
				end
				assert (rdData == holdData)
				else
				begin
					errors++;
					$display("MISMATCH at %0t: rdData expected %h, got %h",
						$time, holdData, rdData);
				end
				assert (rdBank == holdBank)
				else
				begin
					errors++;
					$display("MISMATCH at %0t: rdBank expected %0d, got %0d",
						$time, holdBank, rdBank);
				end
			end
			holdValid = rdValid && !rdReady;
			holdData = rdData;
			holdBank = rdBank;
			if (rdValid && rdReady)
				checkRead();
		end
	end

	// rdReady per cycle, random or counting down a hold
	task automatic tick();
		if (randPhase)
			rdReady = (nextRand() & 32'h3) != 0;
		else if (holdLeft > 0)
		begin
			holdLeft--;
			if (holdLeft == 0)
				rdReady = 1'b1;
		end
	endtask

	task automatic sendCmd(input opE op, input int bank, input int row, input int col,
		input sizeE size, input logic [dataWidth-1:0] data);
		cmdValid = 1'b1;
		cmdOp = op;
		cmdBank = bankBits'(bank);
		cmdRow = rowBits'(row);
		cmdCol = colBits'(col);
		cmdSize = size;
		cmdData = data;
		@(negedge clk);
		while (!cmdReady)
		begin
			@(posedge clk);
			#1;
			tick();
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		tick();
	endtask

	// Legal commands only, from the model's open flags
	task automatic randomCmd();
		logic [31:0] r;
		int bank;
		opE op;
		r = nextRand();
		bank = r[bankBits-1:0];
		if (!modelOpen[bank])
			op = opActivate;
		else if (r[4:2] == 3'd0)
			op = opPrecharge;
		else if (r[4:2] < 3'd4)
			op = opWrite;
		else
			op = opRead;
		sendCmd(op, bank, r[8:5], r[13:9], sizeE'(r[15:14] % 3), nextRand());
	endtask

	initial
	begin
		wait (limit > 0 && cycles >= limit);
		$display("Timeout after %0d cycles, %0d reads never returned", cycles, expDataQ.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		rstN = 1'b0;
		cmdValid = 1'b0;
		cmdOp = opActivate;
		cmdBank = '0;
		cmdRow = '0;
		cmdCol = '0;
		cmdSize = sizeWord;
		cmdData = '0;
		rdReady = 1'b1;
		errors = 0;
		cycles = 0;
		holdLeft = 0;
		randPhase = 1'b0;
		curErr = 1'b0;
		errExp = 1'b0;
		holdValid = 1'b0;
		rngState = 32'h200d;
		for (int i = 0; i < numBanks * numRows * numWords; i++)
			modelMem[i] = '1;
		for (int i = 0; i < numBanks * numWords; i++)
			modelBuf[i] = '0;
		for (int i = 0; i < numBanks; i++)
		begin
			modelOpen[i] = 1'b0;
			modelRow[i] = 0;
		end
		loadTable();
		limit = 20 * (tblOp.size() + numRandom) + 200;

		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(negedge clk);
		assert (!cmdReady)
		else
		begin
			errors++;
			$display("cmdReady was high in the first cycle after reset");
		end
		@(posedge clk);
		#1;

		for (int i = 0; i < tblOp.size(); i++)
		begin
			curErr = tblErr[i];
			if (tblHold[i] > 0)
			begin
				rdReady = 1'b0;
				holdLeft = tblHold[i];
			end
			sendCmd(tblOp[i], tblBank[i], tblRow[i], tblCol[i], tblSize[i], tblData[i]);
		end

		////////////////////////////////////////////////////////////////
		// Random phase
		////////////////////////////////////////////////////////////////
		randPhase = 1'b1;
		curErr = 1'b0;
		repeat (numRandom) randomCmd();

		// Drain outstanding reads
		cmdValid = 1'b0;
		randPhase = 1'b0;
		holdLeft = 0;
		rdReady = 1'b1;
		while (expDataQ.size() > 0 || rdValid)
		begin
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk);

		$display("Errors: %0d, commands: %0d", errors, tblOp.size() + numRandom);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+dv
logic/sdramPkg.sv
logic/sdramCmdDecoder.sv
logic/sdramBank.sv
logic/sdramReadReturn.sv
logic/sdramCore.sv
dv/sdramCoreTb.sv

//--- Bender.yml
package:
  name: sdram_core

sources:
  # Design
  - files:
      - logic/sdramPkg.sv
      - logic/sdramCmdDecoder.sv
      - logic/sdramBank.sv
      - logic/sdramReadReturn.sv
      - logic/sdramCore.sv

  # Testbench
  - target: test
    include_dirs:
      - dv
    files:
      - dv/sdramCoreTb.sv
